// ==== verilog/riscvPkg.sv ====
package riscvPkg;

    // word types
    typedef logic [31:0] word_t;     // data and address word
    typedef logic [4:0]  regAddr_t;  // register index
    typedef logic [6:0]  opcode_t;

    // major opcodes
    localparam opcode_t OPCODE_REG    = 7'b0110011;
    localparam opcode_t OPCODE_IMM    = 7'b0010011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;

    // funct3 for register and immediate ALU ops
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_SUB_SRA = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } aluCtrl_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } brFunc_t;

    // immediate format
    typedef enum logic [2:0] {
        SEXT_I, SEXT_S, SEXT_B, SEXT_U, SEXT_J
    } sextCtrl_t;

    typedef enum logic [1:0] {
        PC_INC,  // pc + 4
        PC_BR,   // conditional branch
        PC_JAL   // JAL or JALR
    } pcSource_t;

    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// ==== verilog/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf import riscvPkg::*; ();

    logic      memToReg, regWrite, memWrite, memRead, jal, lui;
    aluCtrl_t  aluCtrl;
    logic      aluPc;    // 1: pc feeds first operand
    logic      aluImm;   // 1: immediate feeds second operand
    brFunc_t   brFunc;
    logic      jalAddr;  // 1: pc relative target, 0: register base (JALR)
    sextCtrl_t sextOp;
    pcSource_t pcSource;

    modport dec (output memToReg, regWrite, memWrite, memRead, jal, lui,
                 output aluCtrl, aluPc, aluImm, brFunc, jalAddr, sextOp, pcSource);
    modport exe (input aluCtrl, aluPc, aluImm);
    modport fetch (input brFunc, jalAddr, pcSource);
    modport imm (input sextOp);
    modport wb (input memToReg, regWrite, jal, lui, memWrite, memRead);

endinterface

// ==== verilog/control.sv ====
`timescale 1ns/1ps

module control import riscvPkg::*; (
    input  opcode_t    opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    ctrlIf.dec         ctrl
);

    logic altOp;  // subtract or arithmetic shift

    assign altOp = (funct7 == FUNCT7_SUB_SRA);

    always_comb begin
        // safe defaults: no writes, fall through to next instruction
        ctrl.memToReg = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.jal      = 1'b0;
        ctrl.lui      = 1'b0;
        ctrl.aluCtrl  = ALU_ADD;
        ctrl.aluPc    = 1'b0;
        ctrl.aluImm   = 1'b0;
        ctrl.brFunc   = BR_NONE;
        ctrl.jalAddr  = 1'b0;
        ctrl.sextOp   = SEXT_I;
        ctrl.pcSource = PC_INC;

        case (opcode)
            OPCODE_REG, OPCODE_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluImm   = (opcode == OPCODE_IMM);
                unique case (funct3)
                    // no SUBI, so only the register form looks at funct7 here
                    FUNCT3_ADD_SUB: ctrl.aluCtrl = (altOp && opcode == OPCODE_REG) ?
                                                   ALU_SUB : ALU_ADD;
                    FUNCT3_XOR:     ctrl.aluCtrl = ALU_XOR;
                    FUNCT3_OR:      ctrl.aluCtrl = ALU_OR;
                    FUNCT3_AND:     ctrl.aluCtrl = ALU_AND;
                    FUNCT3_SLL:     ctrl.aluCtrl = ALU_SLL;
                    FUNCT3_SRL_SRA: ctrl.aluCtrl = altOp ? ALU_SRA : ALU_SRL;
                    FUNCT3_SLT:     ctrl.aluCtrl = ALU_SLT;
                    FUNCT3_SLTU:    ctrl.aluCtrl = ALU_SLTU;
                endcase
            end
            OPCODE_LOAD: begin
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluImm   = 1'b1;  // base + offset
            end
            OPCODE_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluImm   = 1'b1;
                ctrl.sextOp   = SEXT_S;
            end
            OPCODE_BRANCH: begin
                ctrl.pcSource = PC_BR;
                ctrl.sextOp   = SEXT_B;
                case (funct3)
                    FUNCT3_BEQ:  ctrl.brFunc = BR_BEQ;
                    FUNCT3_BNE:  ctrl.brFunc = BR_BNE;
                    FUNCT3_BLT:  ctrl.brFunc = BR_BLT;
                    FUNCT3_BGE:  ctrl.brFunc = BR_BGE;
                    FUNCT3_BLTU: ctrl.brFunc = BR_BLTU;
                    FUNCT3_BGEU: ctrl.brFunc = BR_BGEU;
                    default:     ctrl.brFunc = BR_NONE;  // reserved, never taken
                endcase
            end
            OPCODE_JAL, OPCODE_JALR: begin
                ctrl.pcSource = PC_JAL;
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;  // link pc + 4
                ctrl.jalAddr  = (opcode == OPCODE_JAL);
                ctrl.sextOp   = (opcode == OPCODE_JAL) ? SEXT_J : SEXT_I;
            end
            OPCODE_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.lui      = 1'b1;
                ctrl.sextOp   = SEXT_U;
            end
            OPCODE_AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluPc    = 1'b1;
                ctrl.aluImm   = 1'b1;
                ctrl.sextOp   = SEXT_U;
            end
            default: ;  // unknown opcode behaves as a no-op
        endcase
    end

endmodule

// ==== verilog/immGen.sv ====
`timescale 1ns/1ps

module immGen import riscvPkg::*; (
    input  word_t instr,
    ctrlIf.imm    ctrl,
    output word_t imm
);

    logic sign;

    assign sign = instr[31];  // all formats keep the sign in bit 31

    always_comb begin
        unique case (ctrl.sextOp)
            SEXT_I: imm = {{20{sign}}, instr[31:20]};
            SEXT_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // branch and jump offsets are in halfwords
            SEXT_B: imm = {{19{sign}}, sign, instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            SEXT_U: imm = {instr[31:12], 12'h000};
            SEXT_J: imm = {{11{sign}}, sign, instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile import riscvPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    input  regAddr_t rdAddr,
    input  word_t    rdData,
    input  logic     we,
    output word_t    rs1Data,
    output word_t    rs2Data
);

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // old value on a same-cycle write
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import riscvPkg::*; (
    ctrlIf.exe    ctrl,
    input  word_t pc,
    input  word_t rs1Data,
    input  word_t rs2Data,
    input  word_t imm,
    output word_t result
);

    word_t      opA;
    word_t      opB;
    logic [4:0] shamt;

    assign opA   = ctrl.aluPc ? pc : rs1Data;    // AUIPC takes pc
    assign opB   = ctrl.aluImm ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        unique case (ctrl.aluCtrl)
            ALU_ADD:  result = opA + opB;
            ALU_SUB:  result = opA - opB;
            ALU_XOR:  result = opA ^ opB;
            ALU_OR:   result = opA | opB;
            ALU_AND:  result = opA & opB;
            ALU_SLL:  result = opA << shamt;
            ALU_SRL:  result = opA >> shamt;
            ALU_SRA:  result = $signed(opA) >>> shamt;
            ALU_SLT: begin
                result = {31'b0, $signed(opA) < $signed(opB)};
            end
            ALU_SLTU: begin
                result = {31'b0, opA < opB};
            end
            default:  result = '0;
        endcase
    end

endmodule

// ==== verilog/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit import riscvPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    ctrlIf.fetch  ctrl,
    input  word_t rs1Data,
    input  word_t rs2Data,
    input  word_t imm,
    output word_t pc
);

    logic  eq, lt, ltu;
    logic  taken;
    word_t pcNext;

    assign eq  = (rs1Data == rs2Data);
    assign lt  = ($signed(rs1Data) < $signed(rs2Data));
    assign ltu = (rs1Data < rs2Data);

    always_comb begin
        unique case (ctrl.brFunc)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = !lt;
            BR_BLTU: taken = ltu;
            BR_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase

        case (ctrl.pcSource)
            PC_BR:   pcNext = taken ? pc + imm : pc + 32'd4;
            PC_JAL:  pcNext = ctrl.jalAddr ? pc + imm
                                           : (rs1Data + imm) & ~32'd1;  // JALR
            default: pcNext = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) pc <= RESET_PC;
        else       pc <= pcNext;
    end

    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

// ==== verilog/riscvCore.sv ====
`timescale 1ns/1ps

module riscvCore import riscvPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    output word_t instrAddr,
    input  word_t instr,
    output word_t dataAddr,
    output word_t dataWdata,
    input  word_t dataRdata,
    output logic  dataWe,
    output logic  dataRe
);

    ctrlIf ctrl ();

    word_t pc, imm, aluResult;
    word_t rs1Data, rs2Data;
    word_t wbData;
    logic  regWe;

    control uControl (.opcode(instr[6:0]), .funct3(instr[14:12]),
                      .funct7(instr[31:25]), .ctrl(ctrl.dec));

    immGen uImmGen (.instr(instr), .ctrl(ctrl.imm), .imm(imm));

    regFile uRegFile (
        .clk(clk), .rstN(rstN),
        .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]), .rdAddr(instr[11:7]),
        .rdData(wbData), .we(regWe),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu uAlu (.ctrl(ctrl.exe), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
              .imm(imm), .result(aluResult));

    pcUnit uPcUnit (.clk(clk), .rstN(rstN), .ctrl(ctrl.fetch), .rs1Data(rs1Data),
                    .rs2Data(rs2Data), .imm(imm), .pc(pc));

    // writeback select
    always_comb begin
        if (ctrl.wb.jal)           wbData = pc + 32'd4;  // link address
        else if (ctrl.wb.lui)      wbData = imm;
        else if (ctrl.wb.memToReg) wbData = dataRdata;
        else                       wbData = aluResult;
    end

    assign regWe = ctrl.wb.regWrite && rstN;  // nothing commits during reset

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign dataWdata = rs2Data;
    assign dataWe    = ctrl.wb.memWrite && rstN;
    assign dataRe    = ctrl.wb.memRead;

    // LW and SW only, a misaligned word has no trap
    assert property (@(posedge clk) disable iff (!rstN)
        (dataWe || dataRe) |-> dataAddr[1:0] == 2'b00);

endmodule

// ==== bench/coreChecker.sv ====
`timescale 1ns/1ps

module coreChecker import riscvPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  word_t instrAddr,
    input  word_t dataAddr,
    input  word_t dataWdata,
    input  logic  dataWe,
    input  logic  dataRe,
    input  word_t prog [0:255],
    input  word_t memInit [0:255],
    output int    errorCount
);

    word_t regs [0:31];
    word_t mem [0:255];  // indexed like the bench data memory
    word_t mpc     = '0;
    logic  inReset = 1'b0;
    int    errors  = 0;

    assign errorCount = errors;

    function automatic word_t aluResultOf(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];  // keeps the sign
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic expectEq(string what, word_t exp, word_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0d ns pc %h: %s expected %h, got %h",
                     $time, mpc, what, exp, act);
        end
    endtask

    // one instruction of the reference model
    task automatic step();
        word_t ins, a, b, immI, immS, immB, immU, immJ, res, addr, next;
        logic  wr;
        ins  = prog[mpc[9:2]];
        a    = regs[ins[19:15]];
        b    = regs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'h000};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        next = mpc + 32'd4;
        res  = '0;
        wr   = 1'b1;
        expectEq("instrAddr", mpc, instrAddr);
        expectEq("dataWe", {31'b0, ins[6:0] == OPCODE_STORE}, {31'b0, dataWe});
        expectEq("dataRe", {31'b0, ins[6:0] == OPCODE_LOAD}, {31'b0, dataRe});
        case (ins[6:0])
            OPCODE_REG:   res = aluResultOf(ins[14:12], ins[30], a, b);
            OPCODE_IMM:   res = aluResultOf(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
            OPCODE_LUI:   res = immU;
            OPCODE_AUIPC: res = mpc + immU;
            OPCODE_JAL: begin
                res  = mpc + 32'd4;
                next = mpc + immJ;
            end
            OPCODE_JALR: begin
                res  = mpc + 32'd4;
                next = (a + immI) & ~32'd1;
            end
            OPCODE_LOAD: begin
                addr = a + immI;
                expectEq("load address", addr, dataAddr);
                res = mem[addr[9:2]];
            end
            OPCODE_STORE: begin
                addr = a + immS;
                wr   = 1'b0;
                expectEq("store address", addr, dataAddr);
                expectEq("store data", b, dataWdata);
                mem[addr[9:2]] = b;
            end
            OPCODE_BRANCH: begin
                wr = 1'b0;
                if (branchTaken(ins[14:12], a, b)) next = mpc + immB;
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
        mpc = next;
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            if (inReset) begin  // pc is cleared by the first reset edge
                expectEq("instrAddr during reset", 32'h0, instrAddr);
                expectEq("dataWe during reset", 32'h0, {31'b0, dataWe});
            end
            inReset = 1'b1;
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            mem = memInit;
            mpc = 32'h0;
        end else begin
            step();
        end
    end

endmodule

// ==== bench/tbCore.sv ====
`timescale 1ns/1ps

module tbCore import riscvPkg::*; ();

    localparam int    PROG_LEN   = 200;
    localparam int    MAX_CYCLES = 2 * PROG_LEN + 20;
    localparam word_t END_ADDR   = word_t'(4 * (PROG_LEN - 1));  // final self-loop

    logic  clk;
    logic  rstN;
    logic  dataWe, dataRe;
    logic  timedOut;
    word_t instrAddr, instr, dataAddr, dataWdata, dataRdata;
    word_t imem [0:255];  // program from address 0
    word_t dmem [0:255];  // data region 0x400 to 0x7fc
    int    cycles;
    int    errorCount;

    riscvCore u_dut (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataRdata(dataRdata),
        .dataWe(dataWe), .dataRe(dataRe)
    );

    coreChecker uCheck (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataWe(dataWe), .dataRe(dataRe),
        .prog(imem), .memInit(dmem), .errorCount(errorCount)
    );

    always #50 clk = ~clk;

    // combinational memories
    assign instr     = imem[instrAddr[9:2]];
    assign dataRdata = dmem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (!rstN) begin
            for (int j = 0; j < 256; j++) begin
                dmem[j] <= (32'h400 + word_t'(4 * j)) * 32'h9e37_79b1;  // whole address
            end
        end else if (dataWe) begin
            dmem[dataAddr[9:2]] <= dataWdata;
        end
    end

    task automatic buildProgram();
        word_t      r, s, off, daddr;
        logic [2:0] f3;
        logic [6:0] f7;
        int         k;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r     = $urandom;
            s     = $urandom;
            f3    = r[14:12];
            f7    = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;  // SUB, SRA
            daddr = 32'h400 + {22'b0, s[19:12], 2'b00};
            k     = int'(s[10:8]) + 1;  // forward distance in instructions
            if (i + k > PROG_LEN - 1) k = PROG_LEN - 1 - i;
            off   = word_t'(4 * k);
            if (i % 8 == 0) begin
                // store a random register so its value shows on the port
                imem[i] = {daddr[11:5], r[24:20], 5'd0, 3'b010, daddr[4:0], OPCODE_STORE};
            end else begin
                case (s % 10)
                    0, 1: imem[i] = {f7, r[24:7], OPCODE_REG};
                    2, 3: begin
                        if (f3 == 3'b001 || f3 == 3'b101) r[31:25] = f7;  // shamt form
                        imem[i] = {r[31:7], OPCODE_IMM};
                    end
                    4: imem[i] = {r[31:7], OPCODE_LUI};
                    5: imem[i] = {r[31:7], OPCODE_AUIPC};
                    6: imem[i] = {daddr[11:0], 5'd0, 3'b010, r[11:7], OPCODE_LOAD};
                    7: begin
                        if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // no branch on 010, 011
                        imem[i] = {off[12], off[10:5], r[24:20], r[19:15], f3,
                                   off[4:1], off[11], OPCODE_BRANCH};
                    end
                    8: imem[i] = {off[20], off[10:1], off[11], off[19:12], r[11:7], OPCODE_JAL};
                    default: begin
                        off     = word_t'(4 * (i + k));  // absolute target, base x0
                        imem[i] = {off[11:0], 5'd0, 3'b000, r[11:7], OPCODE_JALR};
                    end
                endcase
            end
        end
        imem[PROG_LEN - 1] = {20'b0, 5'd0, OPCODE_JAL};  // jal x0, 0
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        cycles   = 0;
        timedOut = 1'b0;
        void'($urandom(32'h4d8f));  // only seeding of the run
        buildProgram();
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        while (instrAddr != END_ADDR && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (instrAddr != END_ADDR) begin
            timedOut = 1'b1;
            $display("timeout: core did not reach its final loop within %0d cycles",
                     MAX_CYCLES);
        end
        repeat (2) @(negedge clk);  // self-loop gets checked as well
        $display("run finished after %0d cycles with %0d errors", cycles, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== riscvCore.f ====
verilog/riscvPkg.sv
verilog/ctrlIf.sv
verilog/control.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/alu.sv
verilog/pcUnit.sv
verilog/riscvCore.sv
bench/coreChecker.sv
bench/tbCore.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f riscvCore.f \
    --top-module tbCore -o simCore \
    && ./obj_dir/simCore > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
